// ==== Makefile ====
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module cacheTb -f tb.f -o cacheSim
	./obj_dir/cacheSim | tee $(LOG)
	grep -q "TEST PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== rtl/apbMemory.sv ====
module apbMemory (
  input  logic       clk,
  input  logic       arstN,
  memBusIf.completer bus
);

  logic [cachePkg::DataWidth-1:0]   memArray [cachePkg::MemWords];
  logic [cachePkg::MemAddrBits-1:0] wordAddr;
  logic [cachePkg::WaitCntBits-1:0] waitCnt;
  logic                             accessPhase;

  // High address bits are ignored, so accesses wrap
  assign wordAddr = bus.paddr[cachePkg::MemAddrBits+cachePkg::ByteOffsetBits-1:
                              cachePkg::ByteOffsetBits];

  assign accessPhase = bus.psel && bus.penable;
  assign bus.pready  = accessPhase && (int'(waitCnt) == cachePkg::MemWaitStates);
  assign bus.prdata  = memArray[wordAddr];

  // Counts access cycles of the current transfer
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      waitCnt <= '0;
    end else if (bus.pready || !accessPhase) begin
      waitCnt <= '0;
    end else begin
      waitCnt <= waitCnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (bus.pready && bus.pwrite) begin
      for (int b = 0; b < cachePkg::StrbWidth; b++) begin
        if (bus.pstrb[b]) begin
          memArray[wordAddr][8*b +: 8] <= bus.pwdata[8*b +: 8];
        end
      end
    end
  end

  // Every completed access phase was entered from a setup cycle
  readyInAccess: assert property (@(posedge clk) disable iff (!arstN)
    bus.pready |-> $past(bus.psel && !bus.penable, cachePkg::MemWaitStates + 1));

endmodule

// ==== rtl/busArbiter.sv ====
module busArbiter (
  input  logic       clk,
  input  logic       arstN,
  memBusIf.completer dReq,
  memBusIf.completer iReq,
  memBusIf.requester mem
);

  typedef enum logic [1:0] {
    OwnNone,
    OwnData,
    OwnInstr
  } ownerT;

  ownerT owner;
  ownerT grant;
  logic  ownerSel;
  logic  selPenable;

  always_comb begin
    unique case (owner)
      OwnData:  ownerSel = dReq.psel;
      OwnInstr: ownerSel = iReq.psel;
      default:  ownerSel = 1'b0;
    endcase
  end

  // Owner holds the bus until its select drops, then data cache first
  always_comb begin
    if (ownerSel) begin
      grant = owner;
    end else if (dReq.psel) begin
      grant = OwnData;
    end else if (iReq.psel) begin
      grant = OwnInstr;
    end else begin
      grant = OwnNone;
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      owner <= OwnNone;
    end else begin
      owner <= grant;
    end
  end

  always_comb begin
    mem.psel   = 1'b0;
    mem.pwrite = 1'b0;
    mem.paddr  = '0;
    mem.pwdata = '0;
    mem.pstrb  = '0;
    selPenable = 1'b0;
    unique case (grant)
      OwnData: begin
        mem.psel   = dReq.psel;
        mem.pwrite = dReq.pwrite;
        mem.paddr  = dReq.paddr;
        mem.pwdata = dReq.pwdata;
        mem.pstrb  = dReq.pstrb;
        selPenable = dReq.penable;
      end
      OwnInstr: begin
        mem.psel   = iReq.psel;
        mem.pwrite = iReq.pwrite;
        mem.paddr  = iReq.paddr;
        mem.pwdata = iReq.pwdata;
        mem.pstrb  = iReq.pstrb;
        selPenable = iReq.penable;
      end
      default: ;
    endcase
  end

  // A waiting requester may already hold penable, so a new grant starts with setup
  assign mem.penable = selPenable && (owner == grant);

  assign dReq.pready = (grant == OwnData) && mem.pready;
  assign dReq.prdata = (grant == OwnData) ? mem.prdata : '0;
  assign iReq.pready = (grant == OwnInstr) && mem.pready;
  assign iReq.prdata = (grant == OwnInstr) ? mem.prdata : '0;

  memStable: assert property (@(posedge clk) disable iff (!arstN)
    mem.penable && !mem.pready |=>
      $stable({mem.pwrite, mem.paddr, mem.pwdata, mem.pstrb}));

endmodule

// ==== rtl/cachePkg.sv ====
package cachePkg;

  // Bus word and byte lanes
  localparam int AddrWidth      = 32;
  localparam int DataWidth      = 32;
  localparam int StrbWidth      = DataWidth / 8;
  localparam int ByteOffsetBits = $clog2(StrbWidth);

  // Line geometry shared by both caches
  localparam int WordsPerLine = 4;
  localparam int OffsetBits   = 2;

  // Instruction cache
  localparam int ICacheLines = 16;
  localparam int IIndexBits  = 4;
  localparam int ITagBits    = AddrWidth - IIndexBits - OffsetBits - ByteOffsetBits;

  // Data cache
  localparam int DCacheLines = 16;
  localparam int DIndexBits  = 4;
  localparam int DTagBits    = AddrWidth - DIndexBits - OffsetBits - ByteOffsetBits;

  // Memory behind the bus wraps above MemWords
  localparam int MemWords    = 1024;
  localparam int MemAddrBits = $clog2(MemWords);

  // Access cycles before pready
  localparam int MemWaitStates = 1;
  localparam int WaitCntBits   = $clog2(MemWaitStates + 1) + 1;

endpackage

// ==== rtl/cacheTop.sv ====
module cacheTop (
  input  logic                           clk,
  input  logic                           arstN,
  input  logic                           iEnable,
  input  logic                           iInvalidate,
  input  logic                           dEnable,
  input  logic                           dInvalidate,
  input  logic                           fetchReq,
  input  logic [cachePkg::AddrWidth-1:0] fetchAddr,
  input  logic                           dataReq,
  input  logic                           dataWrite,
  input  logic [cachePkg::AddrWidth-1:0] dataAddr,
  input  logic [cachePkg::DataWidth-1:0] dataWdata,
  input  logic [cachePkg::StrbWidth-1:0] dataMask,
  output logic [cachePkg::DataWidth-1:0] fetchData,
  output logic                           fetchStall,
  output logic [cachePkg::DataWidth-1:0] dataRdata,
  output logic                           dataStall
);

  memBusIf iBus ();
  memBusIf dBus ();
  memBusIf memBus ();

  instrCache u_instrCache (
    .clk       (clk        ),
    .arstN     (arstN      ),
    .enable    (iEnable    ),
    .invalidate(iInvalidate),
    .fetchReq  (fetchReq   ),
    .fetchAddr (fetchAddr  ),
    .fetchData (fetchData  ),
    .fetchStall(fetchStall ),
    .bus       (iBus       )
  );

  dataCache u_dataCache (
    .clk       (clk        ),
    .arstN     (arstN      ),
    .enable    (dEnable    ),
    .invalidate(dInvalidate),
    .dataReq   (dataReq    ),
    .dataWrite (dataWrite  ),
    .dataAddr  (dataAddr   ),
    .dataWdata (dataWdata  ),
    .dataMask  (dataMask   ),
    .dataRdata (dataRdata  ),
    .dataStall (dataStall  ),
    .bus       (dBus       )
  );

  // Data side wins when both miss together
  busArbiter u_busArbiter (
    .clk  (clk   ),
    .arstN(arstN ),
    .dReq (dBus  ),
    .iReq (iBus  ),
    .mem  (memBus)
  );

  apbMemory u_apbMemory (
    .clk  (clk   ),
    .arstN(arstN ),
    .bus  (memBus)
  );

endmodule

// ==== rtl/dataCache.sv ====
module dataCache (
  input  logic                           clk,
  input  logic                           arstN,
  input  logic                           enable,
  input  logic                           invalidate,
  input  logic                           dataReq,
  input  logic                           dataWrite,
  input  logic [cachePkg::AddrWidth-1:0] dataAddr,
  input  logic [cachePkg::DataWidth-1:0] dataWdata,
  input  logic [cachePkg::StrbWidth-1:0] dataMask,
  output logic [cachePkg::DataWidth-1:0] dataRdata,
  output logic                           dataStall,
  memBusIf.requester                     bus
);

  typedef enum logic [1:0] {
    Idle,
    Fill,
    Single,
    Done
  } stateT;

  stateT                            state;
  logic                             penableQ;
  logic [cachePkg::OffsetBits-1:0]  fillCnt;
  logic [cachePkg::DataWidth-1:0]   holdData;

  logic [cachePkg::DTagBits-1:0]    reqTag;
  logic [cachePkg::DIndexBits-1:0]  reqIndex;
  logic [cachePkg::OffsetBits-1:0]  reqOffset;

  logic [cachePkg::DTagBits-1:0]    tagArr  [cachePkg::DCacheLines];
  logic [cachePkg::DCacheLines-1:0] validArr;
  logic [cachePkg::DataWidth-1:0]   dataArr [cachePkg::DCacheLines][cachePkg::WordsPerLine];

  logic busy;
  logic hit;
  logic wordDone;
  logic fillWord;
  logic lastWord;
  logic writeHit;

  assign {reqTag, reqIndex, reqOffset} =
    dataAddr[cachePkg::AddrWidth-1:cachePkg::ByteOffsetBits];

  assign hit      = enable && validArr[reqIndex] && (tagArr[reqIndex] == reqTag);
  assign busy     = (state == Fill) || (state == Single);
  assign wordDone = penableQ && bus.pready;
  assign fillWord = (state == Fill) && wordDone;
  assign lastWord = fillWord && (int'(fillCnt) == cachePkg::WordsPerLine - 1);
  // The line follows a write only when it already holds the word
  assign writeHit = (state == Single) && wordDone && dataWrite && hit;

  assign bus.psel    = busy;
  assign bus.penable = penableQ;
  assign bus.pwrite  = (state == Single) && dataWrite;
  assign bus.paddr   = {reqTag, reqIndex, ((state == Fill) ? fillCnt : reqOffset),
                        {cachePkg::ByteOffsetBits{1'b0}}};
  assign bus.pwdata  = dataWdata;
  assign bus.pstrb   = bus.pwrite ? dataMask : '0;

  always_comb begin
    unique case (state)
      Idle:    dataStall = dataReq && (dataWrite || !hit);
      Done:    dataStall = 1'b0;
      default: dataStall = 1'b1;
    endcase
  end

  assign dataRdata = (state == Done) ? holdData : dataArr[reqIndex][reqOffset];

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state    <= Idle;
      penableQ <= 1'b0;
      fillCnt  <= '0;
    end else begin
      unique case (state)
        Idle: begin
          fillCnt <= '0;
          if (dataReq && (dataWrite || !enable)) begin
            state <= Single;
          end else if (dataReq && !hit) begin
            state <= Fill;
          end
        end
        Fill: begin
          if (wordDone) begin
            fillCnt <= fillCnt + 1'b1;
            if (lastWord) begin
              state <= Done;
            end
          end
        end
        Single: begin
          if (wordDone) begin
            state <= Done;
          end
        end
        default: state <= Idle;
      endcase
      if (busy && !penableQ) begin
        penableQ <= 1'b1;
      end else if (wordDone) begin
        penableQ <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wordDone && ((state == Single) || (fillCnt == reqOffset))) begin
      holdData <= bus.prdata;
    end
  end

  // Line fill and byte merge on write hits
  always_ff @(posedge clk) begin
    if (fillWord) begin
      dataArr[reqIndex][fillCnt] <= bus.prdata;
    end
    if (lastWord) begin
      tagArr[reqIndex] <= reqTag;
    end
    if (writeHit) begin
      for (int b = 0; b < cachePkg::StrbWidth; b++) begin
        if (dataMask[b]) begin
          dataArr[reqIndex][reqOffset][8*b +: 8] <= dataWdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      validArr <= '0;
    end else if (invalidate) begin
      validArr <= '0;
    end else if (lastWord) begin
      validArr[reqIndex] <= 1'b1;
    end
  end

  enableNeedsSel: assert property (@(posedge clk) disable iff (!arstN)
    bus.penable |-> bus.psel);

endmodule

// ==== rtl/instrCache.sv ====
module instrCache (
  input  logic                           clk,
  input  logic                           arstN,
  input  logic                           enable,
  input  logic                           invalidate,
  input  logic                           fetchReq,
  input  logic [cachePkg::AddrWidth-1:0] fetchAddr,
  output logic [cachePkg::DataWidth-1:0] fetchData,
  output logic                           fetchStall,
  memBusIf.requester                     bus
);

  typedef enum logic [1:0] {
    Idle,
    Fill,
    Uncached,
    Done
  } stateT;

  stateT                            state;
  logic                             penableQ;
  logic [cachePkg::OffsetBits-1:0]  fillCnt;
  logic [cachePkg::DataWidth-1:0]   holdData;

  logic [cachePkg::ITagBits-1:0]    reqTag;
  logic [cachePkg::IIndexBits-1:0]  reqIndex;
  logic [cachePkg::OffsetBits-1:0]  reqOffset;

  logic [cachePkg::ITagBits-1:0]    tagArr  [cachePkg::ICacheLines];
  logic [cachePkg::ICacheLines-1:0] validArr;
  logic [cachePkg::DataWidth-1:0]   dataArr [cachePkg::ICacheLines][cachePkg::WordsPerLine];

  logic busy;
  logic hit;
  logic wordDone;
  logic fillWord;
  logic lastWord;

  assign {reqTag, reqIndex, reqOffset} =
    fetchAddr[cachePkg::AddrWidth-1:cachePkg::ByteOffsetBits];

  assign hit      = enable && validArr[reqIndex] && (tagArr[reqIndex] == reqTag);
  assign busy     = (state == Fill) || (state == Uncached);
  assign wordDone = penableQ && bus.pready;
  assign fillWord = (state == Fill) && wordDone;
  assign lastWord = fillWord && (int'(fillCnt) == cachePkg::WordsPerLine - 1);

  // Read only port with line words from offset zero
  assign bus.psel    = busy;
  assign bus.penable = penableQ;
  assign bus.pwrite  = 1'b0;
  assign bus.paddr   = {reqTag, reqIndex, ((state == Fill) ? fillCnt : reqOffset),
                        {cachePkg::ByteOffsetBits{1'b0}}};
  assign bus.pwdata  = '0;
  assign bus.pstrb   = '0;

  always_comb begin
    unique case (state)
      Idle:    fetchStall = fetchReq && !hit;
      Done:    fetchStall = 1'b0;
      default: fetchStall = 1'b1;
    endcase
  end

  assign fetchData = (state == Done) ? holdData : dataArr[reqIndex][reqOffset];

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state    <= Idle;
      penableQ <= 1'b0;
      fillCnt  <= '0;
    end else begin
      unique case (state)
        Idle: begin
          fillCnt <= '0;
          if (fetchReq && !enable) begin
            state <= Uncached;
          end else if (fetchReq && !hit) begin
            state <= Fill;
          end
        end
        Fill: begin
          if (wordDone) begin
            fillCnt <= fillCnt + 1'b1;
            if (lastWord) begin
              state <= Done;
            end
          end
        end
        Uncached: begin
          if (wordDone) begin
            state <= Done;
          end
        end
        default: state <= Idle;
      endcase
      // One setup cycle ahead of every word
      if (busy && !penableQ) begin
        penableQ <= 1'b1;
      end else if (wordDone) begin
        penableQ <= 1'b0;
      end
    end
  end

  // Requested word is kept for the closing cycle
  always_ff @(posedge clk) begin
    if (wordDone && ((state == Uncached) || (fillCnt == reqOffset))) begin
      holdData <= bus.prdata;
    end
  end

  always_ff @(posedge clk) begin
    if (fillWord) begin
      dataArr[reqIndex][fillCnt] <= bus.prdata;
    end
    if (lastWord) begin
      tagArr[reqIndex] <= reqTag;
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      validArr <= '0;
    end else if (invalidate) begin
      validArr <= '0;
    end else if (lastWord) begin
      validArr[reqIndex] <= 1'b1;
    end
  end

  fetchHeld: assert property (@(posedge clk) disable iff (!arstN)
    fetchStall |=> fetchReq && $stable(fetchAddr));

endmodule

// ==== rtl/memBusIf.sv ====
interface memBusIf;

  // Request side
  logic                             psel;
  logic                             penable;
  logic                             pwrite;
  logic [cachePkg::AddrWidth-1:0]   paddr;
  logic [cachePkg::DataWidth-1:0]   pwdata;
  logic [cachePkg::StrbWidth-1:0]   pstrb;

  // Response side
  logic [cachePkg::DataWidth-1:0]   prdata;
  logic                             pready;

  modport requester (
    output psel,
    output penable,
    output pwrite,
    output paddr,
    output pwdata,
    output pstrb,
    input  prdata,
    input  pready
  );

  modport completer (
    input  psel,
    input  penable,
    input  pwrite,
    input  paddr,
    input  pwdata,
    input  pstrb,
    output prdata,
    output pready
  );

endinterface

// ==== tb.f ====
+incdir+testbench
rtl/cachePkg.sv
rtl/memBusIf.sv
rtl/instrCache.sv
rtl/dataCache.sv
rtl/busArbiter.sv
rtl/apbMemory.sv
rtl/cacheTop.sv
testbench/cacheTb.sv

// ==== testbench/cacheTbTable.svh ====
`ifndef CACHE_TB_TABLE_SVH
`define CACHE_TB_TABLE_SVH

// Operations the table can apply to the DUT
typedef enum logic [2:0] {
  OpWrite,
  OpRead,
  OpFetch,
  OpInvI,
  OpInvD,
  OpEnables,
  OpDual
} opT;

// For OpEnables the mask carries {iEnable, dEnable} in bits 1 and 0
typedef struct {
  string       name;
  opT          op;
  logic [31:0] addr;
  logic [31:0] wdata;
  logic [3:0]  mask;
  logic [31:0] expected;
  bit          expectHit;
} testEntryT;

testEntryT tests[$];

task automatic addEntry(input string name, input opT op, input logic [31:0] addr,
                        input logic [31:0] wdata, input logic [3:0] mask,
                        input logic [31:0] expected, input bit expectHit);
  testEntryT entry;
  entry.name      = name;
  entry.op        = op;
  entry.addr      = addr;
  entry.wdata     = wdata;
  entry.mask      = mask;
  entry.expected  = expected;
  entry.expectHit = expectHit;
  tests.push_back(entry);
endtask

task automatic loadTable();
  // Fill one line through memory, then hit the other words
  addEntry("write 0x40", OpWrite, 32'h40, 32'h1122_3344, 4'hF, 32'h0, 0);
  addEntry("write 0x44", OpWrite, 32'h44, 32'hA5A5_0001, 4'hF, 32'h0, 0);
  addEntry("write 0x48", OpWrite, 32'h48, 32'h5566_7788, 4'hF, 32'h0, 0);
  addEntry("write 0x4c", OpWrite, 32'h4C, 32'hDEAD_0004, 4'hF, 32'h0, 0);
  addEntry("read 0x40 miss", OpRead, 32'h40, 32'h0, 4'h0, 32'h1122_3344, 0);
  addEntry("read 0x44 hit", OpRead, 32'h44, 32'h0, 4'h0, 32'hA5A5_0001, 1);
  addEntry("read 0x48 hit", OpRead, 32'h48, 32'h0, 4'h0, 32'h5566_7788, 1);
  addEntry("read 0x4c hit", OpRead, 32'h4C, 32'h0, 4'h0, 32'hDEAD_0004, 1);
  // Partial writes into a cached line
  addEntry("write 0x48 low half", OpWrite, 32'h48, 32'h0000_BEEF, 4'h3, 32'h0, 0);
  addEntry("read 0x48 merged", OpRead, 32'h48, 32'h0, 4'h0, 32'h5566_BEEF, 1);
  addEntry("write 0x40 top byte", OpWrite, 32'h40, 32'h9900_0000, 4'h8, 32'h0, 0);
  addEntry("read 0x40 merged", OpRead, 32'h40, 32'h0, 4'h0, 32'h9922_3344, 1);
  // Instruction side sees data writes only after a miss or an invalidate
  addEntry("write 0x100 first", OpWrite, 32'h100, 32'h0BAD_F00D, 4'hF, 32'h0, 0);
  addEntry("fetch 0x100 miss", OpFetch, 32'h100, 32'h0, 4'h0, 32'h0BAD_F00D, 0);
  addEntry("write 0x100 second", OpWrite, 32'h100, 32'h600D_CAFE, 4'hF, 32'h0, 0);
  addEntry("fetch 0x100 stale", OpFetch, 32'h100, 32'h0, 4'h0, 32'h0BAD_F00D, 1);
  addEntry("invalidate icache", OpInvI, 32'h0, 32'h0, 4'h0, 32'h0, 0);
  addEntry("fetch 0x100 new", OpFetch, 32'h100, 32'h0, 4'h0, 32'h600D_CAFE, 0);
  // Data cache switched off, then back on
  addEntry("write 0x200", OpWrite, 32'h200, 32'h1357_9BDF, 4'hF, 32'h0, 0);
  addEntry("read 0x200 fill", OpRead, 32'h200, 32'h0, 4'h0, 32'h1357_9BDF, 0);
  addEntry("dcache off", OpEnables, 32'h0, 32'h0, 4'h2, 32'h0, 0);
  addEntry("write 0x200 uncached", OpWrite, 32'h200, 32'h2468_ACE0, 4'hF, 32'h0, 0);
  addEntry("read 0x200 uncached", OpRead, 32'h200, 32'h0, 4'h0, 32'h2468_ACE0, 0);
  addEntry("write 0x200 byte 0", OpWrite, 32'h200, 32'h0000_0011, 4'h1, 32'h0, 0);
  addEntry("read 0x200 byte 0", OpRead, 32'h200, 32'h0, 4'h0, 32'h2468_AC11, 0);
  addEntry("dcache on", OpEnables, 32'h0, 32'h0, 4'h3, 32'h0, 0);
  addEntry("invalidate dcache", OpInvD, 32'h0, 32'h0, 4'h0, 32'h0, 0);
  addEntry("read 0x200 refill", OpRead, 32'h200, 32'h0, 4'h0, 32'h2468_AC11, 0);
  addEntry("read 0x40 refill", OpRead, 32'h40, 32'h0, 4'h0, 32'h9922_3344, 0);
  // Both caches miss in the same cycle
  addEntry("write 0x300", OpWrite, 32'h300, 32'h7777_0300, 4'hF, 32'h0, 0);
  addEntry("dual miss 0x300", OpDual, 32'h300, 32'h0, 4'h0, 32'h7777_0300, 0);
endtask

`endif

// ==== testbench/cacheTb.sv ====
module cacheTb;
  timeunit 1ns;
  timeprecision 1ns;

  localparam int ClkPeriod = 100;
  localparam int RandCount = 64;

  logic        clk;
  logic        arstN;
  logic        iEnable;
  logic        iInvalidate;
  logic        dEnable;
  logic        dInvalidate;
  logic        fetchReq;
  logic [31:0] fetchAddr;
  logic        dataReq;
  logic        dataWrite;
  logic [31:0] dataAddr;
  logic [31:0] dataWdata;
  logic [3:0]  dataMask;
  logic [31:0] fetchData;
  logic        fetchStall;
  logic [31:0] dataRdata;
  logic        dataStall;

  `include "cacheTbTable.svh"

  int          testsRun;
  int          failCount;
  bit          tableLoaded;
  testEntryT   entry;
  logic [31:0] dRes;
  logic [31:0] iRes;
  int          dCyc;
  int          iCyc;
  logic [31:0] rngState;
  int          wordIdx;
  logic [31:0] addr;
  logic [31:0] wdata;
  logic [3:0]  mask;
  // Model of memory contents after write-through
  logic [31:0] shadow [cachePkg::MemWords];
  bit          known  [cachePkg::MemWords];

  cacheTop u_cacheTop (
    .clk        (clk        ),
    .arstN      (arstN      ),
    .iEnable    (iEnable    ),
    .iInvalidate(iInvalidate),
    .dEnable    (dEnable    ),
    .dInvalidate(dInvalidate),
    .fetchReq   (fetchReq   ),
    .fetchAddr  (fetchAddr  ),
    .dataReq    (dataReq    ),
    .dataWrite  (dataWrite  ),
    .dataAddr   (dataAddr   ),
    .dataWdata  (dataWdata  ),
    .dataMask   (dataMask   ),
    .fetchData  (fetchData  ),
    .fetchStall (fetchStall ),
    .dataRdata  (dataRdata  ),
    .dataStall  (dataStall  )
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  function automatic logic [31:0] lcgNext(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Holds each request until its stall is low at a falling edge
  task automatic portAccess(input bit doData, input bit doFetch, input bit write,
                            input logic [31:0] reqAddr, input logic [31:0] reqWdata,
                            input logic [3:0] reqMask, output logic [31:0] dResult,
                            output logic [31:0] iResult, output int dCycles,
                            output int iCycles);
    bit dPend;
    bit iPend;
    dPend   = doData;
    iPend   = doFetch;
    dCycles = 0;
    iCycles = 0;
    dResult = '0;
    iResult = '0;
    @(posedge clk);
    dataReq   <= doData;
    dataWrite <= write;
    dataAddr  <= reqAddr;
    dataWdata <= reqWdata;
    dataMask  <= reqMask;
    fetchReq  <= doFetch;
    fetchAddr <= reqAddr;
    while (dPend || iPend) begin
      @(negedge clk);
      if (dPend) begin
        dCycles++;
        if (!dataStall) begin
          dResult = dataRdata;
          dPend   = 1'b0;
        end
      end
      if (iPend) begin
        iCycles++;
        if (!fetchStall) begin
          iResult = fetchData;
          iPend   = 1'b0;
        end
      end
      @(posedge clk);
      if (!dPend) dataReq <= 1'b0;
      if (!iPend) fetchReq <= 1'b0;
    end
  endtask

  task automatic pulseInvalidate(input bit instrSide);
    @(posedge clk);
    iInvalidate <= instrSide;
    dInvalidate <= !instrSide;
    @(posedge clk);
    iInvalidate <= 1'b0;
    dInvalidate <= 1'b0;
  endtask

  task automatic checkResult(input string name, input logic [31:0] expected,
                             input logic [31:0] actual, input int cycles, input bit mustHit);
    testsRun++;
    if (actual !== expected) begin
      failCount++;
      $display("FAILED %s expected %h actual %h", name, expected, actual);
    end else if (mustHit && cycles != 1) begin
      failCount++;
      $display("%s took %0d cycles where a hit should finish in one", name, cycles);
    end else begin
      $display("passed %s", name);
    end
  endtask

  task automatic reportDone(input string name);
    testsRun++;
    $display("done   %s", name);
  endtask

  initial begin : watchdog
    wait (tableLoaded);
    #((tests.size() + RandCount) * 40 * ClkPeriod);
    $display("Timeout: the DUT stopped answering requests before all tests finished");
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    arstN       = 1'b0;
    iEnable     = 1'b1;
    iInvalidate = 1'b0;
    dEnable     = 1'b1;
    dInvalidate = 1'b0;
    fetchReq    = 1'b0;
    fetchAddr   = '0;
    dataReq     = 1'b0;
    dataWrite   = 1'b0;
    dataAddr    = '0;
    dataWdata   = '0;
    dataMask    = '0;
    testsRun    = 0;
    failCount   = 0;
    rngState    = 32'hc4e4_9e7a;
    loadTable();
    tableLoaded = 1'b1;
    repeat (5) @(posedge clk);
    arstN <= 1'b1;

    // No request, so both stalls stay low
    @(negedge clk);
    testsRun++;
    if (fetchStall || dataStall) begin
      failCount++;
      $display("A stall output is high after reset with no request pending");
    end else begin
      $display("passed idle stalls after reset");
    end

    foreach (tests[i]) begin
      entry = tests[i];
      case (entry.op)
        OpWrite: begin
          portAccess(1, 0, 1, entry.addr, entry.wdata, entry.mask, dRes, iRes, dCyc, iCyc);
          reportDone(entry.name);
        end
        OpRead: begin
          portAccess(1, 0, 0, entry.addr, '0, '0, dRes, iRes, dCyc, iCyc);
          checkResult(entry.name, entry.expected, dRes, dCyc, entry.expectHit);
        end
        OpFetch: begin
          portAccess(0, 1, 0, entry.addr, '0, '0, dRes, iRes, dCyc, iCyc);
          checkResult(entry.name, entry.expected, iRes, iCyc, entry.expectHit);
        end
        OpDual: begin
          portAccess(1, 1, 0, entry.addr, '0, '0, dRes, iRes, dCyc, iCyc);
          checkResult({entry.name, " data"}, entry.expected, dRes, dCyc, 0);
          checkResult({entry.name, " fetch"}, entry.expected, iRes, iCyc, 0);
        end
        OpInvI: begin
          pulseInvalidate(1);
          reportDone(entry.name);
        end
        OpInvD: begin
          pulseInvalidate(0);
          reportDone(entry.name);
        end
        default: begin
          @(posedge clk);
          iEnable <= entry.mask[1];
          dEnable <= entry.mask[0];
          reportDone(entry.name);
        end
      endcase
    end

    // 128 words span 32 lines, so every index sees two tags
    for (int n = 0; n < RandCount; n++) begin
      rngState = lcgNext(rngState);
      wordIdx  = 512 + int'(rngState[22:16]);
      addr     = wordIdx * 4;
      if (!known[wordIdx] || rngState[30:28] < 3'd3) begin
        mask = known[wordIdx] ? rngState[27:24] : 4'hF;
        if (mask == 4'h0) mask = 4'hF;
        rngState = lcgNext(rngState);
        wdata    = rngState;
        portAccess(1, 0, 1, addr, wdata, mask, dRes, iRes, dCyc, iCyc);
        for (int b = 0; b < 4; b++) begin
          if (mask[b]) shadow[wordIdx][8*b +: 8] = wdata[8*b +: 8];
        end
        known[wordIdx] = 1'b1;
        reportDone($sformatf("random write %0d at %h", n, addr));
      end else begin
        portAccess(1, 0, 0, addr, '0, '0, dRes, iRes, dCyc, iCyc);
        checkResult($sformatf("random read %0d at %h", n, addr), shadow[wordIdx], dRes,
                    dCyc, 0);
      end
    end

    $display("Summary: %0d tests run, %0d failed", testsRun, failCount);
    if (failCount == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule
